//--- rtl/clocking_pkg.sv
`default_nettype none

package clocking_pkg;

	// --------------------
	// lock and strobe timing
	localparam int LOCK_CYCLES   = 16; // bit clocks from reset release to locked
	localparam int BIT_DEPTH     = 8;  // serial bits per tx word, also the word strobe period
	localparam int ISERDES_DEPTH = 4;  // serial bits per rx word, also the nibble strobe period

	// --------------------
	// counter widths
	localparam int BIT_COUNT_W  = $clog2(BIT_DEPTH);       // 0 .. BIT_DEPTH-1
	localparam int LOCK_COUNT_W = $clog2(LOCK_CYCLES + 1); // must reach LOCK_CYCLES itself

	typedef logic [BIT_COUNT_W-1:0]  bit_count_t;  // position inside the current word
	typedef logic [LOCK_COUNT_W-1:0] lock_count_t; // lock delay counter

endpackage

`default_nettype wire

//--- rtl/lane_pkg.sv
`default_nettype none

package lane_pkg;

	// --------------------
	// lane geometry
	localparam int LANES     = 4; // transmit lanes in the quad
	localparam int TX_WORD_W = 8; // parallel word into each oserdes lane
	localparam int RX_WORD_W = 4; // parallel word out of the iserdes lane

	// --------------------
	// payload types
	typedef logic [TX_WORD_W-1:0] tx_word_t;   // one transmit word, sent msb first
	typedef logic [RX_WORD_W-1:0] rx_word_t;   // one received nibble, first bit in msb
	typedef logic [LANES-1:0]     lane_bits_t; // one serial bit per lane

endpackage

`default_nettype wire

//--- rtl/strobe_gen.sv
`timescale 1ns/10ps
`default_nettype none

// stands in for the pll + bufpll
// waits out a lock delay, then divides the bit clock down into word and nibble strobes
module strobe_gen (
	input  wire  clock,         // bit-rate clock
	input  wire  rst_n,         // sync, active low
	output logic locked,        // strobes are valid
	output logic word_strobe,   // one bit clock in BIT_DEPTH
	output logic nibble_strobe  // one bit clock in ISERDES_DEPTH
);
	import clocking_pkg::*;

	typedef enum logic {
		st_wait_lock, // counting out the lock delay
		st_running    // strobes free-running
	} state_t;

	state_t      state;    // lock fsm
	lock_count_t lock_cnt; // cycles spent waiting for lock
	bit_count_t  bit_cnt;  // bit position within the word

	// --------------------
	// lock fsm and bit counter
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= st_wait_lock;
			lock_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			case (state)
				st_wait_lock: begin
					if (lock_cnt == lock_count_t'(LOCK_CYCLES)) begin
						state   <= st_running; // locked rises on this edge
						bit_cnt <= '0;         // word boundary lines up with lock
					end else begin
						lock_cnt <= lock_cnt + 1'b1;
					end
				end
				st_running: begin
					bit_cnt <= bit_cnt + 1'b1; // wraps every BIT_DEPTH bits
				end
				default: begin
					state <= st_wait_lock;
				end
			endcase
		end
	end

	// --------------------
	// strobe decode
	assign locked        = (state == st_running);
	assign word_strobe   = (bit_cnt == bit_count_t'(BIT_DEPTH - 1)); // last bit of word
	assign nibble_strobe = locked && ((bit_cnt % ISERDES_DEPTH) == (ISERDES_DEPTH - 1));

	// no word strobe may escape before lock
	a_strobe_locked: assert property (@(posedge clock) disable iff (!rst_n)
		word_strobe |-> locked)
		else $error("word_strobe without locked");

	// exactly one word strobe per BIT_DEPTH bit clocks
	a_strobe_gap: assert property (@(posedge clock) disable iff (!rst_n)
		word_strobe |=> !word_strobe [*(BIT_DEPTH - 1)])
		else $error("word_strobe repeated inside one word period");

endmodule

`default_nettype wire

//--- rtl/oserdes_lane.sv
`timescale 1ns/10ps
`default_nettype none

// one transmit lane
// parallel load on the word strobe, then shift out msb first
module oserdes_lane (
	input  wire                    clock,       // bit-rate clock
	input  wire                    rst_n,       // sync, active low
	input  wire                    word_strobe, // load the next word on this edge
	input  wire lane_pkg::tx_word_t word,       // must be stable across the strobe edge
	output logic                   d            // serial out
);
	import lane_pkg::*;

	localparam int W = $bits(tx_word_t);

	tx_word_t shreg; // bit W-1 is on the pin

	// --------------------
	// load / shift
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			shreg <= '0; // line idles low
		end else if (word_strobe) begin
			shreg <= word; // msb goes out next cycle
		end else begin
			shreg <= {shreg[W-2:0], 1'b0}; // zero fill behind the data
		end
	end

	assign d = shreg[W-1];

	// an unknown word on the input would show up here a cycle later
	a_d_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(d))
		else $error("serial out is unknown");

endmodule

`default_nettype wire

//--- rtl/iserdes_lane.sv
`timescale 1ns/10ps
`default_nettype none

// one receive lane
// samples every bit clock, hands out a nibble per nibble strobe
module iserdes_lane (
	input  wire                     clock,         // bit-rate clock
	input  wire                     rst_n,         // sync, active low
	input  wire                     nibble_strobe, // capture on this edge
	input  wire                     data_in,       // serial in
	output lane_pkg::rx_word_t      rx_word,       // oldest sample in the msb
	output logic                    rx_valid       // one cycle per new nibble
);
	import lane_pkg::*;
	import clocking_pkg::*;

	localparam int W = $bits(rx_word_t);

	logic [W-2:0] hist; // previous samples, hist[W-2] oldest

	// --------------------
	// sample history, runs every bit clock
	always_ff @(posedge clock) begin
		hist <= {hist[W-3:0], data_in};
	end

	// --------------------
	// nibble capture
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rx_word  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= nibble_strobe; // pulse follows the capture edge
			if (nibble_strobe) begin
				rx_word <= {hist, data_in}; // current sample lands in bit 0
			end
		end
	end

	// nibbles arrive one per ISERDES_DEPTH bits, never closer
	a_valid_gap: assert property (@(posedge clock) disable iff (!rst_n)
		rx_valid |=> !rx_valid [*(ISERDES_DEPTH - 1)])
		else $error("rx_valid closer than one nibble period");

endmodule

`default_nettype wire

//--- rtl/ocyrus_quad.sv
`timescale 1ns/10ps
`default_nettype none

// four serial transmit lanes plus one receive lane on a common
// bit clock, the strobes come from strobe_gen
module ocyrus_quad (
	input  wire                      clock,       // bit-rate clock
	input  wire                      rst_n,       // sync, active low
	input  wire lane_pkg::tx_word_t  word1,       // lane 0 payload
	input  wire lane_pkg::tx_word_t  word2,       // lane 1 payload
	input  wire lane_pkg::tx_word_t  word3,       // lane 2 payload
	input  wire lane_pkg::tx_word_t  word4,       // lane 3 payload
	input  wire                      data_in,     // serial in for the rx lane
	output lane_pkg::lane_bits_t     d_out,       // serial out, one bit per lane
	output logic                     word_strobe, // source updates words after this
	output lane_pkg::rx_word_t       rx_word,     // received nibble
	output logic                     rx_valid,    // rx_word is new
	output logic                     locked       // strobes running
);
	import lane_pkg::*;

	logic     nibble_strobe;   // rx capture timing
	tx_word_t words [LANES];   // word inputs as an array for the generate loop

	// --------------------
	// clock and strobe generation
	strobe_gen strobe_gen_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.locked        (locked),
		.word_strobe   (word_strobe),
		.nibble_strobe (nibble_strobe)
	);

	// --------------------
	// transmit lanes
	assign words[0] = word1;
	assign words[1] = word2;
	assign words[2] = word3;
	assign words[3] = word4;

	for (genvar i = 0; i < LANES; i++) begin : g_tx
		oserdes_lane oserdes_lane_i (
			.clock       (clock),
			.rst_n       (rst_n),
			.word_strobe (word_strobe), // all lanes load on the same edge
			.word        (words[i]),
			.d           (d_out[i])
		);
	end

	// --------------------
	// receive lane
	iserdes_lane iserdes_lane_i (
		.clock         (clock),
		.rst_n         (rst_n),
		.nibble_strobe (nibble_strobe),
		.data_in       (data_in),
		.rx_word       (rx_word),
		.rx_valid      (rx_valid)
	);

endmodule

`default_nettype wire

//--- sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// expected-value rules

// the cycle after the load edge carries the msb, one bit lower per cycle after that
function automatic logic serial_bit(input tx_word_t w, input int cycle);
	return w[TX_WORD_W - 1 - cycle];
endfunction

// lane 0 looped back: high half comes out first, low half a nibble later
function automatic rx_word_t loopback_nibble(input tx_word_t w, input bit high);
	return high ? w[7:4] : w[3:0];
endfunction

// --------------------
// check helpers

task automatic check_val(input int test_id, input string name,
		input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		$display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
		test_errors[test_id]++;
	end
endtask

// returns on the falling edge where word_strobe is seen, gap counts falling edges
task automatic wait_word_strobe(input int test_id, output int gap);
	gap = 0;
	do begin
		@(negedge clock);
		gap++;
	end while (word_strobe !== 1'b1 && gap < 2 * BIT_DEPTH);
	assert (word_strobe === 1'b1) else begin
		$display("word_strobe did not show up within %0d cycles (at %0d ns)", gap, $time);
		test_errors[test_id]++;
	end
endtask

// two cycles of reset, outputs must read back as the reset state
task automatic hold_reset(input int test_id);
	rst_n = 1'b0;
	repeat (2) begin
		@(negedge clock);
		check_val(test_id, "locked", locked, 0);
		check_val(test_id, "word_strobe", word_strobe, 0);
		check_val(test_id, "rx_valid", rx_valid, 0);
		check_val(test_id, "rx_word", rx_word, 0);
		check_val(test_id, "d_out", d_out, 0);
	end
	rst_n = 1'b1; // first edge with rst_n high is the next rising edge
endtask

// locked low for LOCK_CYCLES edges after release, high on the next one
task automatic check_lock_delay(input int test_id);
	for (int i = 0; i < LOCK_CYCLES; i++) begin
		@(negedge clock);
		check_val(test_id, "locked", locked, 0);
		check_val(test_id, "word_strobe", word_strobe, 0);
		check_val(test_id, "d_out", d_out, 0);
	end
	@(negedge clock);
	check_val(test_id, "locked", locked, 1);
endtask

// first strobe one word minus a bit after lock, then one per word
task automatic check_strobe_period(input int test_id);
	int gap;
	wait_word_strobe(test_id, gap);
	check_val(test_id, "locked-to-word_strobe cycles", gap, BIT_DEPTH - 1);
	repeat (3) begin
		wait_word_strobe(test_id, gap);
		check_val(test_id, "word_strobe period", gap, BIT_DEPTH);
	end
endtask

// rx side, cycle counts falling edges after the load edge of cur
task automatic check_rx(input int cycle, input tx_word_t cur, input tx_word_t prev);
	if (cycle == 0) begin
		check_val(T_RX, "rx_valid", rx_valid, 1);
		check_val(T_RX, "rx_word", rx_word, loopback_nibble(prev, 1'b0)); // tail of last word
	end else if (cycle == ISERDES_DEPTH) begin
		check_val(T_RX, "rx_valid", rx_valid, 1);
		check_val(T_RX, "rx_word", rx_word, loopback_nibble(cur, 1'b1));
	end else begin
		check_val(T_RX, "rx_valid", rx_valid, 0);
	end
endtask

`endif

//--- sim/tb_ocyrus.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ocyrus;
	import clocking_pkg::*;
	import lane_pkg::*;

	localparam int          CLK_PERIOD  = 4;        // ns
	localparam int          TABLE_LEN   = 12;       // entries of four words
	localparam logic [31:0] SEED        = 32'h4c9f;
	localparam int          WATCHDOG_NS = (LOCK_CYCLES + BIT_DEPTH * (TABLE_LEN + 4))
		* CLK_PERIOD * 2;

	localparam int T_LOCK   = 1; // test ids
	localparam int T_STROBE = 2;
	localparam int T_SERIAL = 3;
	localparam int T_RX     = 4;
	localparam int T_RESET  = 5;

	logic       clock;
	logic       rst_n;
	tx_word_t   word1;
	tx_word_t   word2;
	tx_word_t   word3;
	tx_word_t   word4;
	logic       data_in;
	lane_bits_t d_out;
	logic       word_strobe;
	rx_word_t   rx_word;
	logic       rx_valid;
	logic       locked;

	tx_word_t stim [TABLE_LEN][LANES]; // one word per lane per entry
	int       test_errors [1:5];
	int       checks;
	int       total_errors;
	string    test_label [1:5] = '{"lock delay", "strobe period", "serial order",
		"loopback rx", "mid-run reset"};

	ocyrus_quad dut_i (
		.clock       (clock),
		.rst_n       (rst_n),
		.word1       (word1),
		.word2       (word2),
		.word3       (word3),
		.word4       (word4),
		.data_in     (data_in),
		.d_out       (d_out),
		.word_strobe (word_strobe),
		.rx_word     (rx_word),
		.rx_valid    (rx_valid),
		.locked      (locked)
	);

	`include "tb_checks.svh"

	// --------------------
	// stimulus

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic fill_stimulus();
		logic [31:0] rnd;
		rnd = SEED;
		for (int n = 0; n < TABLE_LEN; n++) begin
			for (int k = 0; k < LANES; k++) begin
				rnd = xorshift32(rnd);
				stim[n][k] = rnd[7:0];
			end
		end
		stim[0] = '{8'h00, 8'hFF, 8'hA5, 8'h81}; // corners, rotated so lane 0 sees two
		stim[1] = '{8'hA5, 8'h81, 8'h00, 8'hFF};
	endtask

	task automatic present_words(input tx_word_t w1, input tx_word_t w2,
			input tx_word_t w3, input tx_word_t w4);
		word1 = w1;
		word2 = w2;
		word3 = w3;
		word4 = w4;
	endtask

	// entry n goes on the falling edge after the strobe before it loads
	task automatic apply_entries(input int first, input int last);
		int       gap;
		tx_word_t prev1; // lane 0 word whose low nibble is still in flight
		present_words('0, '0, '0, '0);
		prev1 = '0;
		wait_word_strobe(T_SERIAL, gap);
		@(negedge clock);
		present_words(stim[first][0], stim[first][1], stim[first][2], stim[first][3]);
		wait_word_strobe(T_SERIAL, gap);
		for (int n = first; n <= last; n++) begin
			for (int j = 0; j < BIT_DEPTH; j++) begin
				@(negedge clock); // j edges after the load edge
				if (j == 0 && n < last) begin
					present_words(stim[n+1][0], stim[n+1][1], stim[n+1][2], stim[n+1][3]);
				end
				for (int k = 0; k < LANES; k++) begin
					check_val(T_SERIAL, $sformatf("d_out[%0d]", k), d_out[k],
						serial_bit(stim[n][k], j));
				end
				check_rx(j, stim[n][0], prev1);
			end
			prev1 = stim[n][0];
		end
		@(negedge clock);
		check_rx(0, '0, prev1); // low nibble of the last entry
	endtask

	task automatic report_test(input int test_id);
		$display("test %0d %-14s %s, %0d errors", test_id, test_label[test_id],
			test_errors[test_id] == 0 ? "ok" : "failed", test_errors[test_id]);
	endtask

	// --------------------
	// clock, loopback, watchdog

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(negedge clock) begin
		data_in = d_out[0]; // lane 0 back into the rx lane
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run was still going after %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	// --------------------
	// test sequence

	initial begin
		rst_n   = 1'b0;
		data_in = 1'b0;
		present_words('0, '0, '0, '0);
		checks = 0;
		fill_stimulus();

		hold_reset(T_LOCK);
		check_lock_delay(T_LOCK);
		report_test(T_LOCK);
		check_strobe_period(T_STROBE);
		report_test(T_STROBE);

		apply_entries(0, TABLE_LEN / 2 - 1);
		hold_reset(T_RESET); // lanes still busy with the last entry
		check_lock_delay(T_RESET);
		check_strobe_period(T_RESET);
		report_test(T_RESET);
		apply_entries(TABLE_LEN / 2, TABLE_LEN - 1);
		report_test(T_SERIAL);
		report_test(T_RX);

		total_errors = 0;
		for (int id = 1; id <= 5; id++) begin
			total_errors += test_errors[id];
		end
		$display("%0d checks, %0d errors", checks, total_errors);
		if (total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+sim
rtl/clocking_pkg.sv
rtl/lane_pkg.sv
rtl/strobe_gen.sv
rtl/oserdes_lane.sv
rtl/iserdes_lane.sv
rtl/ocyrus_quad.sv
sim/tb_ocyrus.sv
